// ==== hw/dispatch_defines.svh ====
`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// operand and result width
`define DATA_W 32

// physical register index, 64 registers
`define PREG_W 6

// immediate as delivered by rename, already sign extended
`define IMM_W 32

`define PC_W 32

// rob index, 32 entries, wraps naturally
`define ROB_IDX_W 5

`endif

// ==== hw/dispatch_pkg.sv ====
package dispatch_pkg;

    // opcodes seen by dispatch after rename
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_ADDI = 4'd4,
        OP_MUL  = 4'd5,
        OP_DIV  = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8
    } opcode_e;

    // execution unit class, picks the issue queue
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,
        UNIT_MDU  = 2'd2,
        UNIT_LSU  = 2'd3
    } unit_e;

    // state of the one-entry bundle register
    typedef enum logic {
        BR_EMPTY = 1'b0,
        BR_FULL  = 1'b1
    } bundle_state_e;

endpackage

// ==== hw/bundle_reg.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module bundle_reg (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  ren_valid_i,
    input  dispatch_pkg::opcode_e ren_op_i [2],
    input  logic [`PREG_W-1:0]    ren_preg_i [2],
    input  logic [1:0]            ren_wreg_i,
    input  logic [`PC_W-1:0]      ren_pc_i [2],
    input  logic [`IMM_W-1:0]     ren_imm_i [2],
    input  logic [`PREG_W-1:0]    ren_src_preg_i [4],
    input  logic [`DATA_W-1:0]    ren_arf_data_i [4],
    input  logic [3:0]            ren_src_ready_i,
    input  logic                  fire_i,
    output logic                  ren_ready_o,
    output logic                  full_o,
    output dispatch_pkg::opcode_e op_o [2],
    output logic [`PREG_W-1:0]    preg_o [2],
    output logic [1:0]            wreg_o,
    output logic [`PC_W-1:0]      pc_o [2],
    output logic [`IMM_W-1:0]     imm_o [2],
    output logic [`PREG_W-1:0]    src_preg_o [4],
    output logic [`DATA_W-1:0]    arf_data_o [4],
    output logic [3:0]            src_ready_o
);
    import dispatch_pkg::*;

    bundle_state_e state_q;
    bundle_state_e state_d;
    logic          load;

    assign full_o      = (state_q == BR_FULL);
    // a slot frees up in the same cycle the held bundle leaves
    assign ren_ready_o = (!full_o || fire_i) && !flush_i;
    assign load        = ren_valid_i && ren_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            BR_EMPTY: begin
                if (load) begin
                    state_d = BR_FULL;
                end
            end
            BR_FULL: begin
                if (flush_i) begin
                    state_d = BR_EMPTY;
                end else if (fire_i && !load) begin
                    state_d = BR_EMPTY;
                end
            end
            default: state_d = BR_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= BR_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // payload only moves on an accepted transfer
    always_ff @(posedge clk) begin
        if (load) begin
            op_o        <= ren_op_i;
            preg_o      <= ren_preg_i;
            wreg_o      <= ren_wreg_i;
            pc_o        <= ren_pc_i;
            imm_o       <= ren_imm_i;
            src_preg_o  <= ren_src_preg_i;
            arf_data_o  <= ren_arf_data_i;
            src_ready_o <= ren_src_ready_i;
        end
    end

    // queues stalled, so the bundle seen downstream must not change
    a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
        full_o && !fire_i |=> $stable({op_o[0], op_o[1], preg_o[0], preg_o[1], wreg_o,
                                       pc_o[0], pc_o[1], imm_o[0], imm_o[1],
                                       src_preg_o[0], src_preg_o[1], src_preg_o[2],
                                       src_preg_o[3], arf_data_o[0], arf_data_o[1],
                                       arf_data_o[2], arf_data_o[3], src_ready_o}))
        else $error("bundle changed while held under back-pressure");

endmodule

// ==== hw/uop_decode.sv ====
`timescale 1ns/1ps

module uop_decode (
    input  dispatch_pkg::opcode_e op_i [2],
    input  logic [1:0]            wreg_i,
    output dispatch_pkg::unit_e   unit_o [2],
    output logic [1:0]            use_imm_o,
    output logic [1:0]            wreg_en_o,
    output logic [1:0]            lane_valid_o
);
    import dispatch_pkg::*;

    // register write allowed by the opcode itself
    logic [1:0] op_writes;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            unit_o[l]    = UNIT_NONE;
            use_imm_o[l] = 1'b0;
            op_writes[l] = 1'b1;
            case (op_i[l])
                OP_ADD, OP_SUB, OP_AND: begin
                    unit_o[l] = UNIT_ALU;
                end
                OP_ADDI: begin
                    unit_o[l]    = UNIT_ALU;
                    use_imm_o[l] = 1'b1;
                end
                OP_MUL, OP_DIV: begin
                    unit_o[l] = UNIT_MDU;
                end
                // imm is the address offset
                OP_LD: begin
                    unit_o[l]    = UNIT_LSU;
                    use_imm_o[l] = 1'b1;
                end
                OP_ST: begin
                    unit_o[l]    = UNIT_LSU;
                    use_imm_o[l] = 1'b1;
                    op_writes[l] = 1'b0;
                end
                default: begin
                    // nop, nothing to issue or write
                    op_writes[l] = 1'b0;
                end
            endcase
            // rename may still clear the write, e.g. r0 destination
            wreg_en_o[l]    = op_writes[l] && wreg_i[l];
            lane_valid_o[l] = (unit_o[l] != UNIT_NONE);
        end
    end

endmodule

// ==== hw/operand_select.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module operand_select (
    input  logic                 clk,
    input  logic [`PREG_W-1:0]   src_preg_i [4],
    input  logic [`DATA_W-1:0]   arf_data_i [4],
    input  logic [3:0]           src_ready_i,
    input  logic [`IMM_W-1:0]    imm_i [2],
    input  logic [1:0]           use_imm_i,
    input  logic [1:0]           cdb_valid_i,
    input  logic [`PREG_W-1:0]   cdb_preg_i [2],
    input  logic [`DATA_W-1:0]   cdb_data_i [2],
    input  logic [3:0]           rob_complete_i,
    input  logic [`DATA_W-1:0]   rob_data_i [4],
    input  logic [`PREG_W-1:0]   lane0_preg_i,
    input  logic                 lane0_writes_i,
    input  logic [1:0]           lane_valid_i,
    output logic [`DATA_W-1:0]   src_data_o [4],
    output logic [3:0]           src_ready_o
);
    logic [1:0]         cdb_match [4];
    logic [3:0]         cdb_hit;
    logic [`DATA_W-1:0] cdb_data [4];
    logic [3:0]         imm_sel;
    logic [3:0]         raw_dep;

    // imm only ever replaces source 1 of its lane
    assign imm_sel = {use_imm_i[1], 1'b0, use_imm_i[0], 1'b0};

    // snoop both cdb ports for every source
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            cdb_data[i] = '0;
            for (int j = 0; j < 2; j++) begin
                cdb_match[i][j] = cdb_valid_i[j] && (cdb_preg_i[j] == src_preg_i[i]);
                if (cdb_match[i][j]) begin
                    cdb_data[i] = cdb_data[i] | cdb_data_i[j];
                end
            end
            cdb_hit[i] = |cdb_match[i];
        end
    end

    // lane 1 reading what lane 0 of the same bundle produces
    always_comb begin
        raw_dep = '0;
        for (int i = 2; i < 4; i++) begin
            raw_dep[i] = lane_valid_i[0] && lane0_writes_i && (src_preg_i[i] == lane0_preg_i);
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (imm_sel[i]) begin
                src_data_o[i] = `DATA_W'(imm_i[i >> 1]);
            end else if (src_ready_i[i]) begin
                src_data_o[i] = arf_data_i[i];
            end else if (cdb_hit[i]) begin
                src_data_o[i] = cdb_data[i];
            end else begin
                src_data_o[i] = rob_data_i[i];
            end
            src_ready_o[i] = imm_sel[i] || src_ready_i[i] || cdb_hit[i] || rob_complete_i[i];
            // rob/cdb copy is stale, wait for lane 0 to broadcast
            if (raw_dep[i] && !imm_sel[i] && !src_ready_i[i]) begin
                src_ready_o[i] = 1'b0;
            end
        end
    end

    // the two execution ports never broadcast the same preg together
    for (genvar g = 0; g < 4; g++) begin : g_cdb_chk
        a_cdb_onehot: assert property (@(posedge clk)
            lane_valid_i[g / 2] |-> $onehot0(cdb_match[g]))
            else $error("source %0d matched both cdb ports", g);
    end

endmodule

// ==== hw/dispatch_route.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module dispatch_route (
    input  logic                clk,
    input  logic                full_i,
    input  logic                flush_i,
    input  logic [3:0]          iq_ready_i,
    input  dispatch_pkg::unit_e unit_i [2],
    input  logic [`PREG_W-1:0]  preg_i [2],
    input  logic [1:0]          lane_valid_i,
    output logic                fire_o,
    output logic [3:0]          iq_valid_o,
    output logic [1:0]          iq_lane_sel_o [4]
);
    import dispatch_pkg::*;

    // whole bundle moves at once, so every queue must have room
    assign fire_o = full_i && (&iq_ready_i) && !flush_i;

    // queue order is alu0, alu1, mdu, lsu
    always_comb begin
        for (int q = 0; q < 4; q++) begin
            iq_lane_sel_o[q] = '0;
        end
        for (int l = 0; l < 2; l++) begin
            if (lane_valid_i[l]) begin
                case (unit_i[l])
                    UNIT_ALU: begin
                        // odd destinations to alu1
                        if (preg_i[l][0]) begin
                            iq_lane_sel_o[1][l] = 1'b1;
                        end else begin
                            iq_lane_sel_o[0][l] = 1'b1;
                        end
                    end
                    UNIT_MDU: iq_lane_sel_o[2][l] = 1'b1;
                    UNIT_LSU: iq_lane_sel_o[3][l] = 1'b1;
                    default: ;
                endcase
            end
        end
        for (int q = 0; q < 4; q++) begin
            iq_valid_o[q] = fire_o && (|iq_lane_sel_o[q]);
        end
    end

    // a decoded lane lands in exactly one queue
    for (genvar g = 0; g < 2; g++) begin : g_route_chk
        a_one_queue: assert property (@(posedge clk)
            full_i && lane_valid_i[g] |-> $onehot({iq_lane_sel_o[3][g], iq_lane_sel_o[2][g],
                                                  iq_lane_sel_o[1][g], iq_lane_sel_o[0][g]}))
            else $error("lane %0d not routed to exactly one queue", g);
    end

endmodule

// ==== hw/rob_write.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module rob_write (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    input  logic                  fire_i,
    input  logic [1:0]            lane_valid_i,
    output logic [1:0]            rob_we_o,
    output logic [`ROB_IDX_W-1:0] rob_idx_o [2]
);
    logic [`ROB_IDX_W-1:0] tail_q;
    logic [`ROB_IDX_W-1:0] alloc_cnt;

    // entries taken by this bundle, zero to two
    assign alloc_cnt = `ROB_IDX_W'(lane_valid_i[0]) + `ROB_IDX_W'(lane_valid_i[1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            tail_q <= '0;
        end else if (flush_i) begin
            // rob is emptied alongside
            tail_q <= '0;
        end else if (fire_i) begin
            tail_q <= tail_q + alloc_cnt;
        end
    end

    // nop in lane 0 leaves the tail slot to lane 1
    assign rob_idx_o[0] = tail_q;
    assign rob_idx_o[1] = lane_valid_i[0] ? tail_q + `ROB_IDX_W'(1) : tail_q;
    assign rob_we_o     = lane_valid_i & {2{fire_i}};

endmodule

// ==== hw/dispatch_top.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module dispatch_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  flush_i,
    // rename side
    input  logic                  ren_valid_i,
    output logic                  ren_ready_o,
    input  dispatch_pkg::opcode_e ren_op_i [2],
    input  logic [`PREG_W-1:0]    ren_preg_i [2],
    input  logic [1:0]            ren_wreg_i,
    input  logic [`PC_W-1:0]      ren_pc_i [2],
    input  logic [`IMM_W-1:0]     ren_imm_i [2],
    input  logic [`PREG_W-1:0]    ren_src_preg_i [4],
    input  logic [`DATA_W-1:0]    ren_arf_data_i [4],
    input  logic [3:0]            ren_src_ready_i,
    // cdb snoop
    input  logic [1:0]            cdb_valid_i,
    input  logic [`PREG_W-1:0]    cdb_preg_i [2],
    input  logic [`DATA_W-1:0]    cdb_data_i [2],
    // rob read-back per source
    input  logic [3:0]            rob_complete_i,
    input  logic [`DATA_W-1:0]    rob_data_i [4],
    // issue queues: alu0, alu1, mdu, lsu
    output logic [3:0]            iq_valid_o,
    input  logic [3:0]            iq_ready_i,
    output logic [1:0]            iq_lane_sel_o [4],
    output dispatch_pkg::opcode_e iq_op_o [2],
    output logic [`PREG_W-1:0]    iq_preg_o [2],
    output logic [1:0]            iq_wreg_o,
    output logic [`IMM_W-1:0]     iq_imm_o [2],
    output logic [`PC_W-1:0]      iq_pc_o [2],
    output logic [`DATA_W-1:0]    iq_src_data_o [4],
    output logic [3:0]            iq_src_ready_o,
    output logic [`PREG_W-1:0]    iq_src_preg_o [4],
    // rob allocation
    output logic [1:0]            rob_we_o,
    output logic [`ROB_IDX_W-1:0] rob_idx_o [2],
    output logic [`PC_W-1:0]      rob_pc_o [2],
    output logic [`PREG_W-1:0]    rob_preg_o [2]
);
    logic                full;
    logic                fire;
    logic [1:0]          wreg_q;
    logic [`DATA_W-1:0]  arf_data_q [4];
    logic [3:0]          src_ready_q;
    dispatch_pkg::unit_e unit [2];
    logic [1:0]          use_imm;
    logic [1:0]          lane_valid;

    // held bundle drives the queue fields directly
    bundle_reg u_bundle (
        .*,
        .fire_i      (fire),
        .full_o      (full),
        .op_o        (iq_op_o),
        .preg_o      (iq_preg_o),
        .wreg_o      (wreg_q),
        .pc_o        (iq_pc_o),
        .imm_o       (iq_imm_o),
        .src_preg_o  (iq_src_preg_o),
        .arf_data_o  (arf_data_q),
        .src_ready_o (src_ready_q)
    );

    uop_decode u_decode (
        .op_i         (iq_op_o),
        .wreg_i       (wreg_q),
        .unit_o       (unit),
        .use_imm_o    (use_imm),
        .wreg_en_o    (iq_wreg_o),
        .lane_valid_o (lane_valid)
    );

    operand_select u_opsel (
        .*,
        .src_preg_i     (iq_src_preg_o),
        .arf_data_i     (arf_data_q),
        .src_ready_i    (src_ready_q),
        .imm_i          (iq_imm_o),
        .use_imm_i      (use_imm),
        .lane0_preg_i   (iq_preg_o[0]),
        .lane0_writes_i (iq_wreg_o[0]),
        .lane_valid_i   (lane_valid),
        .src_data_o     (iq_src_data_o),
        .src_ready_o    (iq_src_ready_o)
    );

    dispatch_route u_route (
        .*,
        .full_i       (full),
        .unit_i       (unit),
        .preg_i       (iq_preg_o),
        .lane_valid_i (lane_valid),
        .fire_o       (fire)
    );

    rob_write u_rob_wr (
        .*,
        .fire_i       (fire),
        .lane_valid_i (lane_valid)
    );

    assign rob_pc_o   = iq_pc_o;
    assign rob_preg_o = iq_preg_o;

endmodule

// ==== test/tb_dispatch.sv ====
`timescale 1ns/1ps
`include "dispatch_defines.svh"

module tb_dispatch;
    import dispatch_pkg::*;

    localparam int NUM_CYCLES    = 2000;
    localparam int DRAIN_TIMEOUT = 50;

    logic                  clk;
    logic                  reset_i;
    logic                  flush_i;
    logic                  ren_valid_i;
    logic                  ren_ready_o;
    opcode_e               ren_op_i [2];
    logic [`PREG_W-1:0]    ren_preg_i [2];
    logic [1:0]            ren_wreg_i;
    logic [`PC_W-1:0]      ren_pc_i [2];
    logic [`IMM_W-1:0]     ren_imm_i [2];
    logic [`PREG_W-1:0]    ren_src_preg_i [4];
    logic [`DATA_W-1:0]    ren_arf_data_i [4];
    logic [3:0]            ren_src_ready_i;
    logic [1:0]            cdb_valid_i;
    logic [`PREG_W-1:0]    cdb_preg_i [2];
    logic [`DATA_W-1:0]    cdb_data_i [2];
    logic [3:0]            rob_complete_i;
    logic [`DATA_W-1:0]    rob_data_i [4];
    logic [3:0]            iq_valid_o;
    logic [3:0]            iq_ready_i;
    logic [1:0]            iq_lane_sel_o [4];
    opcode_e               iq_op_o [2];
    logic [`PREG_W-1:0]    iq_preg_o [2];
    logic [1:0]            iq_wreg_o;
    logic [`IMM_W-1:0]     iq_imm_o [2];
    logic [`PC_W-1:0]      iq_pc_o [2];
    logic [`DATA_W-1:0]    iq_src_data_o [4];
    logic [3:0]            iq_src_ready_o;
    logic [`PREG_W-1:0]    iq_src_preg_o [4];
    logic [1:0]            rob_we_o;
    logic [`ROB_IDX_W-1:0] rob_idx_o [2];
    logic [`PC_W-1:0]      rob_pc_o [2];
    logic [`PREG_W-1:0]    rob_preg_o [2];

    // reference copy of the held bundle
    logic                  m_full;
    opcode_e               m_op [2];
    logic [`PREG_W-1:0]    m_preg [2];
    logic [1:0]            m_wreg;
    logic [`PC_W-1:0]      m_pc [2];
    logic [`IMM_W-1:0]     m_imm [2];
    logic [`PREG_W-1:0]    m_src_preg [4];
    logic [`DATA_W-1:0]    m_arf [4];
    logic [3:0]            m_src_rdy;
    logic [`ROB_IDX_W-1:0] m_tail;

    logic [15:0] lfsr_q;
    int          err_cnt;
    int          acc_cnt;
    int          fire_cnt;
    int          drop_cnt;

    logic         exp_fire;
    logic         exp_ready;
    logic [1:0]   exp_lane_valid;
    logic [1:0]   exp_writes;
    logic [3:0]   exp_iq_valid;
    logic [3:0]   exp_src_rdy;
    // lane select packed as {lsu, mdu, alu1, alu0} with two lanes each
    logic [7:0]   exp_sel;
    logic [7:0]   act_sel;
    logic [127:0] exp_src_data;
    logic [127:0] act_src_data;
    logic [9:0]   exp_rob_idx;
    logic [9:0]   act_rob_idx;
    logic [247:0] exp_hold;
    logic [247:0] act_hold;

    dispatch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] exp_v,
                                   input logic [255:0] act_v);
        err_cnt++;
        $display("CHECK FAILED %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
    endtask

    task automatic drive_random();
        logic [2:0] cdb_base;
        logic [1:0] cdb_off;
        ren_valid_i = (rand_bits(2) != 0);
        for (int l = 0; l < 2; l++) begin
            ren_op_i[l]   = opcode_e'(4'(rand_bits(8) % 9));
            // small register range so sources and destinations collide often
            ren_preg_i[l] = `PREG_W'(rand_bits(3));
            ren_wreg_i[l] = (rand_bits(2) != 0);
            ren_pc_i[l]   = rand_bits(32);
            ren_imm_i[l]  = rand_bits(32);
        end
        for (int i = 0; i < 4; i++) begin
            ren_src_preg_i[i]  = `PREG_W'(rand_bits(3));
            ren_arf_data_i[i]  = rand_bits(32);
            ren_src_ready_i[i] = rand_bits(1);
            rob_complete_i[i]  = rand_bits(1);
            rob_data_i[i]      = rand_bits(32);
            iq_ready_i[i]      = (rand_bits(3) != 0);
        end
        // the two cdb ports never carry the same register
        cdb_base      = 3'(rand_bits(3));
        cdb_off       = 2'(rand_bits(2));
        cdb_preg_i[0] = `PREG_W'(cdb_base);
        cdb_preg_i[1] = `PREG_W'(cdb_base ^ {cdb_off, 1'b1});
        for (int j = 0; j < 2; j++) begin
            cdb_valid_i[j] = rand_bits(1);
            cdb_data_i[j]  = rand_bits(32);
        end
        flush_i = (rand_bits(5) == 0);
    endtask

    always_comb begin : p_expect
        logic               imm;
        logic               hit;
        logic               hazard;
        logic [`DATA_W-1:0] cdb_val;
        logic [`DATA_W-1:0] data;
        exp_fire  = m_full && (&iq_ready_i) && !flush_i;
        exp_ready = (!m_full || exp_fire) && !flush_i;
        exp_sel   = '0;
        for (int l = 0; l < 2; l++) begin
            exp_lane_valid[l] = (m_op[l] != OP_NOP);
            exp_writes[l]     = exp_lane_valid[l] && (m_op[l] != OP_ST) && m_wreg[l];
            case (m_op[l])
                OP_NOP: ;
                OP_MUL, OP_DIV: exp_sel[4 + l] = 1'b1;
                OP_LD, OP_ST: exp_sel[6 + l] = 1'b1;
                default: exp_sel[(m_preg[l][0] ? 2 : 0) + l] = 1'b1;
            endcase
        end
        for (int q = 0; q < 4; q++) begin
            exp_iq_valid[q] = exp_fire && (|exp_sel[2*q +: 2]);
        end
        exp_rob_idx = {m_tail + `ROB_IDX_W'(exp_lane_valid[0]), m_tail};
        for (int i = 0; i < 4; i++) begin
            imm = (i % 2 == 1) && (m_op[i/2] == OP_ADDI || m_op[i/2] == OP_LD ||
                                   m_op[i/2] == OP_ST);
            hit     = 1'b0;
            cdb_val = '0;
            for (int j = 0; j < 2; j++) begin
                if (cdb_valid_i[j] && cdb_preg_i[j] == m_src_preg[i]) begin
                    hit     = 1'b1;
                    cdb_val = cdb_data_i[j];
                end
            end
            hazard = (i >= 2) && exp_writes[0] && (m_src_preg[i] == m_preg[0]);
            if (imm) begin
                data = m_imm[i/2];
            end else if (m_src_rdy[i]) begin
                data = m_arf[i];
            end else if (hit) begin
                data = cdb_val;
            end else begin
                data = rob_data_i[i];
            end
            exp_src_data[i*32 +: 32] = data;
            exp_src_rdy[i] = (imm || m_src_rdy[i] || hit || rob_complete_i[i]) &&
                             !(hazard && !imm && !m_src_rdy[i]);
        end
    end

    assign act_sel      = {iq_lane_sel_o[3], iq_lane_sel_o[2], iq_lane_sel_o[1], iq_lane_sel_o[0]};
    assign act_src_data = {iq_src_data_o[3], iq_src_data_o[2], iq_src_data_o[1], iq_src_data_o[0]};
    assign act_rob_idx  = {rob_idx_o[1], rob_idx_o[0]};
    assign exp_hold = {m_op[1], m_op[0], m_preg[1], m_preg[0], m_pc[1], m_pc[0], m_imm[1],
                       m_imm[0], m_src_preg[3], m_src_preg[2], m_src_preg[1], m_src_preg[0],
                       m_pc[1], m_pc[0], m_preg[1], m_preg[0]};
    assign act_hold = {iq_op_o[1], iq_op_o[0], iq_preg_o[1], iq_preg_o[0], iq_pc_o[1],
                       iq_pc_o[0], iq_imm_o[1], iq_imm_o[0], iq_src_preg_o[3],
                       iq_src_preg_o[2], iq_src_preg_o[1], iq_src_preg_o[0], rob_pc_o[1],
                       rob_pc_o[0], rob_preg_o[1], rob_preg_o[0]};

    // model of bundle register occupancy and rob tail
    always_ff @(posedge clk) begin
        if (reset_i) begin
            m_full <= 1'b0;
            m_tail <= '0;
        end else begin
            // bundles with a real lane, counted where the dut shows them
            if (ren_valid_i && ren_ready_o &&
                (ren_op_i[0] != OP_NOP || ren_op_i[1] != OP_NOP)) begin
                acc_cnt <= acc_cnt + 1;
            end
            if (|rob_we_o) begin
                fire_cnt <= fire_cnt + 1;
            end
            if (flush_i && m_full && (|exp_lane_valid)) begin
                drop_cnt <= drop_cnt + 1;
            end
            if (ren_valid_i && exp_ready) begin
                m_full     <= 1'b1;
                m_op       <= ren_op_i;
                m_preg     <= ren_preg_i;
                m_wreg     <= ren_wreg_i;
                m_pc       <= ren_pc_i;
                m_imm      <= ren_imm_i;
                m_src_preg <= ren_src_preg_i;
                m_arf      <= ren_arf_data_i;
                m_src_rdy  <= ren_src_ready_i;
            end else if (flush_i || exp_fire) begin
                m_full <= 1'b0;
            end
            if (flush_i) begin
                m_tail <= '0;
            end else if (exp_fire) begin
                m_tail <= m_tail + `ROB_IDX_W'(exp_lane_valid[0]) +
                          `ROB_IDX_W'(exp_lane_valid[1]);
            end
        end
    end

    a_ren_ready: assert property (@(posedge clk) disable iff (reset_i)
        ren_ready_o == exp_ready)
        else report_mismatch("ren_ready", $sampled(exp_ready), $sampled(ren_ready_o));
    a_iq_valid: assert property (@(posedge clk) disable iff (reset_i)
        iq_valid_o == exp_iq_valid)
        else report_mismatch("iq_valid", $sampled(exp_iq_valid), $sampled(iq_valid_o));
    a_rob_we: assert property (@(posedge clk) disable iff (reset_i)
        rob_we_o == (exp_lane_valid & {2{exp_fire}}))
        else report_mismatch("rob_we", $sampled(exp_lane_valid & {2{exp_fire}}),
                             $sampled(rob_we_o));
    a_lane_sel: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> act_sel == exp_sel)
        else report_mismatch("lane_sel", $sampled(exp_sel), $sampled(act_sel));
    a_src_data: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> act_src_data == exp_src_data)
        else report_mismatch("src_data", $sampled(exp_src_data), $sampled(act_src_data));
    a_src_ready: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> iq_src_ready_o == exp_src_rdy)
        else report_mismatch("src_ready", $sampled(exp_src_rdy), $sampled(iq_src_ready_o));
    a_wreg: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> iq_wreg_o == exp_writes)
        else report_mismatch("wreg", $sampled(exp_writes), $sampled(iq_wreg_o));
    a_rob_idx: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> act_rob_idx == exp_rob_idx)
        else report_mismatch("rob_idx", $sampled(exp_rob_idx), $sampled(act_rob_idx));
    // also covers stability under back-pressure
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
        m_full |-> act_hold == exp_hold)
        else report_mismatch("bundle_fields", $sampled(exp_hold), $sampled(act_hold));

    initial begin
        int waited;
        lfsr_q  = 16'd71;
        reset_i = 1'b1;
        drive_random();
        ren_valid_i = 1'b0;
        flush_i     = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_random();
            @(negedge clk);
        end
        // drain whatever is still held
        ren_valid_i = 1'b0;
        flush_i     = 1'b0;
        iq_ready_i  = '1;
        waited      = 0;
        while (m_full && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (m_full) begin
            err_cnt++;
            $display("timeout: held bundle never dispatched with all queues ready");
        end else begin
            assert (acc_cnt == fire_cnt + drop_cnt)
                else report_mismatch("bundle_count", acc_cnt, fire_cnt + drop_cnt);
        end
        $display("accepted %0d fired %0d flushed %0d errors %0d",
                 acc_cnt, fire_cnt, drop_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/dispatch_pkg.sv
hw/bundle_reg.sv
hw/uop_decode.sv
hw/operand_select.sv
hw/dispatch_route.sv
hw/rob_write.sv
hw/dispatch_top.sv
test/tb_dispatch.sv

// ==== Bender.yml ====
package:
  name: dispatch

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dispatch_pkg.sv
      - hw/bundle_reg.sv
      - hw/uop_decode.sv
      - hw/operand_select.sv
      - hw/dispatch_route.sv
      - hw/rob_write.sv
      - hw/dispatch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_dispatch.sv
